// ==== rtl/decomp_pkg.sv ====
// shared types, opcode and register constants, result structs for the rvc expander

package decomp_pkg;

  //////////////////////////////////////////////////////////////////////
  // word and field types
  //////////////////////////////////////////////////////////////////////

  // full 32-bit instruction word
  typedef logic [31:0] instr_t;

  // compressed halfword, as found in the low half of a fetch word
  typedef logic [15:0] cinstr_t;

  // major opcode field, bits 6:0
  typedef logic [6:0]  opcode_t;

  // architectural register index
  typedef logic [4:0]  reg_idx_t;

  //////////////////////////////////////////////////////////////////////
  // rv32i opcodes used by the expansions
  //////////////////////////////////////////////////////////////////////

  localparam opcode_t OPCODE_OPIMM  = 7'h13;
  localparam opcode_t OPCODE_OP     = 7'h33;
  localparam opcode_t OPCODE_LUI    = 7'h37;
  localparam opcode_t OPCODE_LOAD   = 7'h03;
  localparam opcode_t OPCODE_STORE  = 7'h23;
  localparam opcode_t OPCODE_BRANCH = 7'h63;
  localparam opcode_t OPCODE_JAL    = 7'h6f;
  localparam opcode_t OPCODE_JALR   = 7'h67;

  // fixed registers implied by some compressed forms
  localparam reg_idx_t REG_ZERO = 5'd0;
  localparam reg_idx_t REG_RA   = 5'd1;
  localparam reg_idx_t REG_SP   = 5'd2;

  // c.ebreak has no operands, it maps to one fixed word
  localparam instr_t INSTR_EBREAK = 32'h0010_0073;

  //////////////////////////////////////////////////////////////////////
  // result structs
  //////////////////////////////////////////////////////////////////////

  // output of one quadrant decoder
  typedef struct packed {
    instr_t instr;
    logic   illegal;
  } expand_t;

  // registered output of the expander
  // is_compressed is low for words whose bits 1:0 are 11
  typedef struct packed {
    instr_t instr;
    logic   is_compressed;
    logic   illegal;
  } decomp_out_t;

endpackage

// ==== rtl/decomp_quad0.sv ====
// quadrant c0 expander: c.addi4spn, c.lw, c.sw, everything else illegal
`timescale 1ns/100ps

module decomp_quad0 (
  input  decomp_pkg::cinstr_t  cinstr_i,
  output decomp_pkg::expand_t  expand_o
);

  import decomp_pkg::*;

  logic [2:0] funct3;
  // primed registers, x8..x15
  reg_idx_t   rd_p;
  reg_idx_t   rs1_p;
  // lw form, shared by c.lw and all the illegal slots
  instr_t     lw_word;

  assign funct3 = cinstr_i[15:13];
  assign rd_p   = {2'b01, cinstr_i[4:2]};
  assign rs1_p  = {2'b01, cinstr_i[9:7]};

  // word offset is uimm[6:2], scaled by 4
  assign lw_word = {5'b0, cinstr_i[5], cinstr_i[12:10], cinstr_i[6], 2'b00,
                    rs1_p, 3'b010, rd_p, OPCODE_LOAD};

  always_comb begin
    expand_o.instr   = lw_word;
    expand_o.illegal = 1'b0;
    unique case (funct3)
      3'b000: begin
        // c.addi4spn, addi rd', sp, nzuimm
        // immediate is scaled by 4, zero immediate is reserved
        expand_o.instr = {2'b0, cinstr_i[10:7], cinstr_i[12:11], cinstr_i[5],
                          cinstr_i[6], 2'b00, REG_SP, 3'b000, rd_p, OPCODE_OPIMM};
        expand_o.illegal = (cinstr_i[12:5] == 8'b0);
      end
      3'b010: begin
        // c.lw
        expand_o.instr = lw_word;
      end
      3'b110: begin
        // c.sw, rs2' sits in the lower register slot
        expand_o.instr = {5'b0, cinstr_i[5], cinstr_i[12], rd_p, rs1_p, 3'b010,
                          cinstr_i[11:10], cinstr_i[6], 2'b00, OPCODE_STORE};
      end
      default: begin
        // c.fld, c.flw, c.fsd, c.fsw and the reserved or zc slots
        // word kept at the lw form so the output stays deterministic
        expand_o.instr   = lw_word;
        expand_o.illegal = 1'b1;
      end
    endcase
  end

endmodule

// ==== rtl/decomp_quad1.sv ====
// quadrant c1 expander: immediate ops, jumps, branches, register alu ops
`timescale 1ns/100ps

module decomp_quad1 (
  input  decomp_pkg::cinstr_t  cinstr_i,
  output decomp_pkg::expand_t  expand_o
);

  import decomp_pkg::*;

  logic [2:0]  funct3;
  // full register field and primed register fields
  reg_idx_t    rd;
  reg_idx_t    rd_p;
  reg_idx_t    rs2_p;
  // sign-extended 6-bit immediate, imm[5] is bit 12
  logic [11:0] imm6_sext;
  // register alu form, funct7 and funct3 filled in per op
  logic [6:0]  alu_funct7;
  logic [2:0]  alu_funct3;

  assign funct3    = cinstr_i[15:13];
  assign rd        = cinstr_i[11:7];
  assign rd_p      = {2'b01, cinstr_i[9:7]};
  assign rs2_p     = {2'b01, cinstr_i[4:2]};
  assign imm6_sext = {{7{cinstr_i[12]}}, cinstr_i[6:2]};

  // sub, xor, or, and selected by bits 6:5
  always_comb begin
    alu_funct7 = 7'b0;
    unique case (cinstr_i[6:5])
      2'b00: begin
        alu_funct7 = 7'b0100000;
        alu_funct3 = 3'b000;
      end
      2'b01: alu_funct3 = 3'b100;
      2'b10: alu_funct3 = 3'b110;
      default: alu_funct3 = 3'b111;
    endcase
  end

  always_comb begin
    expand_o.instr   = {imm6_sext, rd, 3'b000, rd, OPCODE_OPIMM};
    expand_o.illegal = 1'b0;
    unique case (funct3)
      3'b000: begin
        // c.addi, c.nop and the rd=x0 or zero-imm hints all take this form
        expand_o.instr = {imm6_sext, rd, 3'b000, rd, OPCODE_OPIMM};
      end
      3'b001, 3'b101: begin
        // c.jal links to ra, c.j links to x0
        // offset bits are scattered, imm[11] and imm[19:12] are sign copies
        expand_o.instr = {cinstr_i[12], cinstr_i[8], cinstr_i[10:9], cinstr_i[6],
                          cinstr_i[7], cinstr_i[2], cinstr_i[11], cinstr_i[5:3],
                          {9{cinstr_i[12]}},
                          (cinstr_i[15] ? REG_ZERO : REG_RA), OPCODE_JAL};
      end
      3'b010: begin
        // c.li, addi rd, x0, imm
        // rd=x0 is a hint and expands the same way
        expand_o.instr = {imm6_sext, REG_ZERO, 3'b000, rd, OPCODE_OPIMM};
      end
      3'b011: begin
        if (rd == REG_SP) begin
          // c.addi16sp, immediate scaled by 16
          expand_o.instr = {{3{cinstr_i[12]}}, cinstr_i[4:3], cinstr_i[5], cinstr_i[2],
                            cinstr_i[6], 4'b0, REG_SP, 3'b000, REG_SP, OPCODE_OPIMM};
        end else begin
          // c.lui, rd=x0 is a hint
          expand_o.instr = {{15{cinstr_i[12]}}, cinstr_i[6:2], rd, OPCODE_LUI};
        end
        // zero immediate is reserved for both forms
        expand_o.illegal = ({cinstr_i[12], cinstr_i[6:2]} == 6'b0);
      end
      3'b100: begin
        unique case (cinstr_i[11:10])
          2'b00, 2'b01: begin
            // c.srli / c.srai, bit 10 picks arithmetic
            // shamt[5] set is rv64 only
            expand_o.instr = {1'b0, cinstr_i[10], 5'b0, cinstr_i[6:2], rd_p, 3'b101,
                              rd_p, OPCODE_OPIMM};
            expand_o.illegal = cinstr_i[12];
          end
          2'b10: begin
            // c.andi
            expand_o.instr = {imm6_sext, rd_p, 3'b111, rd_p, OPCODE_OPIMM};
          end
          default: begin
            expand_o.instr = {alu_funct7, rs2_p, rd_p, alu_funct3, rd_p, OPCODE_OP};
            // bit 12 set: c.subw, c.addw and reserved slots
            expand_o.illegal = cinstr_i[12];
          end
        endcase
      end
      default: begin
        // c.beqz / c.bnez, bit 13 becomes funct3[0]
        expand_o.instr = {{4{cinstr_i[12]}}, cinstr_i[6:5], cinstr_i[2], REG_ZERO, rd_p,
                          2'b00, cinstr_i[13], cinstr_i[11:10], cinstr_i[4:3],
                          cinstr_i[12], OPCODE_BRANCH};
      end
    endcase
  end

endmodule

// ==== rtl/decomp_quad2.sv ====
// quadrant c2 expander: c.slli, sp-relative load/store, jr/mv/jalr/add, ebreak
`timescale 1ns/100ps

module decomp_quad2 (
  input  decomp_pkg::cinstr_t  cinstr_i,
  output decomp_pkg::expand_t  expand_o
);

  import decomp_pkg::*;

  logic [2:0] funct3;
  reg_idx_t   rd;
  reg_idx_t   rs2;
  // lwsp form, also used for the floating-point slots
  instr_t     lwsp_word;

  assign funct3 = cinstr_i[15:13];
  assign rd     = cinstr_i[11:7];
  assign rs2    = cinstr_i[6:2];

  // offset is uimm[7:2], scaled by 4
  assign lwsp_word = {4'b0, cinstr_i[3:2], cinstr_i[12], cinstr_i[6:4], 2'b00,
                      REG_SP, 3'b010, rd, OPCODE_LOAD};

  always_comb begin
    expand_o.instr   = lwsp_word;
    expand_o.illegal = 1'b0;
    unique case (funct3)
      3'b000: begin
        // c.slli, zero shamt or rd=x0 are hints
        expand_o.instr   = {7'b0, rs2, rd, 3'b001, rd, OPCODE_OPIMM};
        expand_o.illegal = cinstr_i[12];
      end
      3'b010: begin
        // c.lwsp, rd=x0 is reserved
        expand_o.instr   = lwsp_word;
        expand_o.illegal = (rd == REG_ZERO);
      end
      3'b100: begin
        if (!cinstr_i[12]) begin
          if (rs2 == REG_ZERO) begin
            // c.jr, rs1=x0 is reserved
            expand_o.instr   = {12'b0, rd, 3'b000, REG_ZERO, OPCODE_JALR};
            expand_o.illegal = (rd == REG_ZERO);
          end else begin
            // c.mv, add rd, x0, rs2
            expand_o.instr = {7'b0, rs2, REG_ZERO, 3'b000, rd, OPCODE_OP};
          end
        end else begin
          if (rs2 == REG_ZERO && rd == REG_ZERO) begin
            expand_o.instr = INSTR_EBREAK;
          end else if (rs2 == REG_ZERO) begin
            // c.jalr links to ra
            expand_o.instr = {12'b0, rd, 3'b000, REG_RA, OPCODE_JALR};
          end else begin
            // c.add, rd=x0 is a hint
            expand_o.instr = {7'b0, rs2, rd, 3'b000, rd, OPCODE_OP};
          end
        end
      end
      3'b110: begin
        // c.swsp, offset uimm[7:2]
        expand_o.instr = {4'b0, cinstr_i[8:7], cinstr_i[12], rs2, REG_SP, 3'b010,
                          cinstr_i[11:9], 2'b00, OPCODE_STORE};
      end
      default: begin
        // c.fldsp, c.flwsp, c.fsdsp, c.fswsp
        expand_o.instr   = lwsp_word;
        expand_o.illegal = 1'b1;
      end
    endcase
  end

endmodule

// ==== rtl/decomp_stage.sv ====
// quadrant select, 32-bit pass-through and the output register of the expander
`timescale 1ns/100ps

module decomp_stage (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    valid_i,
  input  decomp_pkg::instr_t      instr_i,
  input  decomp_pkg::expand_t     quad0_i,
  input  decomp_pkg::expand_t     quad1_i,
  input  decomp_pkg::expand_t     quad2_i,
  output logic                    valid_o,
  output decomp_pkg::decomp_out_t result_o
);

  import decomp_pkg::*;

  // combinational result, captured on valid
  decomp_out_t result_d;

  //////////////////////////////////////////////////////////////////////
  // quadrant select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    result_d.is_compressed = (instr_i[1:0] != 2'b11);
    unique case (instr_i[1:0])
      2'b00: begin
        result_d.instr   = quad0_i.instr;
        result_d.illegal = quad0_i.illegal;
      end
      2'b01: begin
        result_d.instr   = quad1_i.instr;
        result_d.illegal = quad1_i.illegal;
      end
      2'b10: begin
        result_d.instr   = quad2_i.instr;
        result_d.illegal = quad2_i.illegal;
      end
      default: begin
        // full-width word, passed on untouched and never flagged
        result_d.instr   = instr_i;
        result_d.illegal = 1'b0;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////////////////////////

  // valid follows the input strobe by one cycle
  // result only loads on valid and holds across gaps
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o  <= 1'b0;
      result_o <= '0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        result_o <= result_d;
      end
    end
  end

endmodule

// ==== rtl/decomp_top.sv ====
// top level of the rvc expander: three quadrant decoders feeding one register stage
`timescale 1ns/100ps

module decomp_top (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    valid_i,
  input  decomp_pkg::instr_t      instr_i,
  output logic                    valid_o,
  output decomp_pkg::decomp_out_t result_o
);

  import decomp_pkg::*;

  // per-quadrant expansions of the low halfword
  expand_t quad0_res;
  expand_t quad1_res;
  expand_t quad2_res;

  // all three decoders see the same halfword every cycle
  decomp_quad0 i_decomp_quad0 (
    .cinstr_i (instr_i[15:0]),
    .expand_o (quad0_res)
  );

  decomp_quad1 i_decomp_quad1 (
    .cinstr_i (instr_i[15:0]),
    .expand_o (quad1_res)
  );

  decomp_quad2 i_decomp_quad2 (
    .cinstr_i (instr_i[15:0]),
    .expand_o (quad2_res)
  );

  // select by bits 1:0 and register
  decomp_stage i_decomp_stage (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .valid_i  (valid_i),
    .instr_i  (instr_i),
    .quad0_i  (quad0_res),
    .quad1_i  (quad1_res),
    .quad2_i  (quad2_res),
    .valid_o  (valid_o),
    .result_o (result_o)
  );

endmodule

// ==== bench/decomp_asserts.sv ====
// bound assertions on output valid timing and result flag consistency of the expander
`timescale 1ns/100ps

module decomp_asserts (
  input logic                    clk_i,
  input logic                    rst_n_i,
  input logic                    valid_i,
  input decomp_pkg::instr_t      instr_i,
  input logic                    valid_o,
  input decomp_pkg::decomp_out_t result_o
);

  import decomp_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // valid timing
  //////////////////////////////////////////////////////////////////////

  // one cycle of latency, no more and no less
  valid_delay_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_i |=> valid_o)
    else $error("valid_o missing one cycle after valid_i");

  gap_follow_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !valid_i |=> !valid_o)
    else $error("valid_o high after a gap in valid_i");

  reset_low_a: assert property (@(posedge clk_i) !rst_n_i |-> !valid_o)
    else $error("valid_o high during reset");

  //////////////////////////////////////////////////////////////////////
  // flags
  //////////////////////////////////////////////////////////////////////

  // is_compressed tracks bits 1:0 of the word that was captured
  compressed_flag_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_i |=> (result_o.is_compressed == ($past(instr_i[1:0]) != 2'b11)))
    else $error("is_compressed does not match the captured word");

  illegal_needs_c_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (valid_o && result_o.illegal) |-> result_o.is_compressed)
    else $error("illegal set on a 32-bit word");

endmodule

bind decomp_top decomp_asserts i_decomp_asserts (.*);

// ==== bench/decomp_tb.sv ====
// testbench for the rvc expander: clock, reset, stimulus, reference expansion, output checks
`timescale 1ns/100ps

module decomp_tb;

  import decomp_pkg::*;

  logic        clk_i;
  logic        rst_n_i;
  logic        valid_i;
  instr_t      instr_i;
  logic        valid_o;
  decomp_out_t result_o;

  integer      seed;
  string       cur_test;
  decomp_out_t exp_q[$];
  // valid_i as seen one cycle earlier, and the last captured result
  logic        valid_d;
  decomp_out_t held_result;

  // one of every kept expansion, hints and ebreak included
  localparam int N_LEGAL = 35;
  localparam logic [15:0] LEGAL_HW [N_LEGAL] = '{
    16'h0040, 16'h4188, 16'hc188, 16'h0505, 16'h0001, 16'h2001, 16'h3ffd,
    16'ha001, 16'hbffd, 16'h4505, 16'h6141, 16'h7179, 16'h6505, 16'h8105,
    16'h8505, 16'h8905, 16'h8c05, 16'h8c25, 16'h8c45, 16'h8c65, 16'hc101,
    16'he101, 16'h0506, 16'h4502, 16'h8082, 16'h852e, 16'h9002, 16'h9502,
    16'h952e, 16'hc02a, 16'h0005, 16'h4005, 16'h6005, 16'h0006, 16'h900a
  };
  // reserved, floating-point, rv64 and zc slots
  localparam int N_ILLEGAL = 24;
  localparam logic [15:0] ILLEGAL_HW [N_ILLEGAL] = '{
    16'h0000, 16'h2000, 16'h6000, 16'h8000, 16'ha000, 16'he000, 16'h8c88,
    16'h6501, 16'h6101, 16'h9105, 16'h9505, 16'h9c05, 16'h9c25, 16'h9c45,
    16'h9c65, 16'h1506, 16'h4002, 16'h8002, 16'h2002, 16'h6002, 16'ha002,
    16'he002, 16'h3000, 16'hb002
  };

  decomp_top i_decomp_top (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .valid_i  (valid_i),
    .instr_i  (instr_i),
    .valid_o  (valid_o),
    .result_o (result_o)
  );

  always #20 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // rv32i encoders and reference expansion
  //////////////////////////////////////////////////////////////////////

  function automatic instr_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                   reg_idx_t rd, opcode_t op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic instr_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPCODE_STORE};
  endfunction

  function automatic instr_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                   logic [2:0] f3, reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OPCODE_OP};
  endfunction

  function automatic decomp_out_t ref_expand(instr_t w);
    decomp_out_t r;
    logic [15:0] c;
    reg_idx_t    rd;
    reg_idx_t    rdp;
    reg_idx_t    rs2;
    reg_idx_t    rs2p;
    logic [11:0] imm6;
    logic [20:0] joff;
    logic [12:0] boff;
    logic [2:0]  f3;
    c    = w[15:0];
    rd   = c[11:7];
    rs2  = c[6:2];
    rdp  = 5'd8 + {2'b00, c[9:7]};
    rs2p = 5'd8 + {2'b00, c[4:2]};
    imm6 = {{7{c[12]}}, c[6:2]};
    r.instr = w;
    r.is_compressed = (w[1:0] != 2'b11);
    r.illegal = 1'b0;
    case ({w[1:0], c[15:13]})
      5'b00_000: begin
        r.instr = enc_i({2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00}, REG_SP, 3'd0,
                        rs2p, OPCODE_OPIMM);
        r.illegal = (c[12:5] == 8'h00);
      end
      5'b00_010: r.instr = enc_i({5'd0, c[5], c[12:10], c[6], 2'b00}, rdp, 3'd2, rs2p,
                                 OPCODE_LOAD);
      5'b00_110: r.instr = enc_s({5'd0, c[5], c[12:10], c[6], 2'b00}, rs2p, rdp);
      5'b01_000: r.instr = enc_i(imm6, rd, 3'd0, rd, OPCODE_OPIMM);
      5'b01_001, 5'b01_101: begin
        joff = {{10{c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
        r.instr = {joff[20], joff[10:1], joff[11], joff[19:12],
                   (c[15] ? REG_ZERO : REG_RA), OPCODE_JAL};
      end
      5'b01_010: r.instr = enc_i(imm6, REG_ZERO, 3'd0, rd, OPCODE_OPIMM);
      5'b01_011: begin
        if (rd == REG_SP) begin
          r.instr = enc_i({{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'h0}, REG_SP, 3'd0,
                          REG_SP, OPCODE_OPIMM);
        end else begin
          r.instr = {{15{c[12]}}, c[6:2], rd, OPCODE_LUI};
        end
        r.illegal = (imm6 == 12'h000);
      end
      5'b01_100: begin
        case (c[11:10])
          2'b00: r.instr = enc_i({7'h00, c[6:2]}, rdp, 3'd5, rdp, OPCODE_OPIMM);
          2'b01: r.instr = enc_i({7'h20, c[6:2]}, rdp, 3'd5, rdp, OPCODE_OPIMM);
          2'b10: r.instr = enc_i(imm6, rdp, 3'd7, rdp, OPCODE_OPIMM);
          default: begin
            f3 = (c[6:5] == 2'd0) ? 3'd0 : (c[6:5] == 2'd1) ? 3'd4 :
                 (c[6:5] == 2'd2) ? 3'd6 : 3'd7;
            r.instr = enc_r((c[6:5] == 2'd0) ? 7'h20 : 7'h00, rs2p, rdp, f3, rdp);
          end
        endcase
        // shamt[5] on shifts, subw/addw and reserved slots on the alu group
        r.illegal = c[12] && (c[11:10] != 2'b10);
      end
      5'b01_110, 5'b01_111: begin
        boff = {{5{c[12]}}, c[6:5], c[2], c[11:10], c[4:3], 1'b0};
        r.instr = {boff[12], boff[10:5], REG_ZERO, rdp, 2'b00, c[13], boff[4:1],
                   boff[11], OPCODE_BRANCH};
      end
      5'b10_000: begin
        r.instr = enc_i({7'h00, c[6:2]}, rd, 3'd1, rd, OPCODE_OPIMM);
        r.illegal = c[12];
      end
      5'b10_010: begin
        r.instr = enc_i({4'h0, c[3:2], c[12], c[6:4], 2'b00}, REG_SP, 3'd2, rd,
                        OPCODE_LOAD);
        r.illegal = (rd == 5'd0);
      end
      5'b10_100: begin
        if (!c[12] && rs2 == 5'd0) begin
          r.instr = enc_i(12'h000, rd, 3'd0, REG_ZERO, OPCODE_JALR);
          r.illegal = (rd == 5'd0);
        end else if (!c[12]) begin
          r.instr = enc_r(7'h00, rs2, REG_ZERO, 3'd0, rd);
        end else if (rs2 == 5'd0 && rd == 5'd0) begin
          r.instr = 32'h0010_0073;
        end else if (rs2 == 5'd0) begin
          r.instr = enc_i(12'h000, rd, 3'd0, REG_RA, OPCODE_JALR);
        end else begin
          r.instr = enc_r(7'h00, rs2, rd, 3'd0, rd);
        end
      end
      5'b10_110: r.instr = enc_s({4'h0, c[8:7], c[12:9], 2'b00}, rs2, REG_SP);
      default: begin
        // everything left in c0 and c2 is illegal, 32-bit words keep the defaults
        if (w[1:0] != 2'b11) begin
          r.illegal = 1'b1;
        end
      end
    endcase
    return r;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // check, drive and compare
  //////////////////////////////////////////////////////////////////////

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("[ERROR] %s: expected %08h, actual %08h", name, exp, act);
      $display("*** TEST FAILED ***");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic send_word(input instr_t w);
    @(posedge clk_i);
    valid_i <= 1'b1;
    instr_i <= w;
    exp_q.push_back(ref_expand(w));
  endtask

  // drop valid and put junk on the bus, the result must hold
  task automatic idle_cycle();
    @(posedge clk_i);
    valid_i <= 1'b0;
    instr_i <= $random(seed);
  endtask

  // sampled mid-cycle, away from the edge where the register changes
  always @(negedge clk_i) begin
    decomp_out_t e;
    if (!rst_n_i) begin
      check({cur_test, " reset valid"}, 32'd0, {31'd0, valid_o});
      check({cur_test, " reset result"}, 32'd0, result_o[33:2]);
      check({cur_test, " reset flags"}, 32'd0, {30'd0, result_o[1:0]});
      valid_d     <= 1'b0;
      held_result <= '0;
    end else begin
      check({cur_test, " valid timing"}, {31'd0, valid_d}, {31'd0, valid_o});
      if (valid_o) begin
        if (exp_q.size() == 0) begin
          $display("output valid with no word outstanding in %s", cur_test);
          $display("*** TEST FAILED ***");
          $fatal(1, "unexpected output");
        end
        e = exp_q.pop_front();
        check({cur_test, " is_compressed"}, {31'd0, e.is_compressed},
              {31'd0, result_o.is_compressed});
        check({cur_test, " illegal"}, {31'd0, e.illegal}, {31'd0, result_o.illegal});
        // the word under an illegal flag is don't care
        if (!e.illegal) begin
          check({cur_test, " instr"}, e.instr, result_o.instr);
        end
        held_result <= result_o;
      end else begin
        check({cur_test, " held result"}, held_result[33:2], result_o[33:2]);
        check({cur_test, " held flags"}, {30'd0, held_result[1:0]},
              {30'd0, result_o[1:0]});
      end
      valid_d <= valid_i;
    end
  end

  initial begin
    int wait_cnt;
    instr_t w;
    seed     = 32'he58178e6;
    clk_i    = 1'b0;
    rst_n_i  = 1'b0;
    valid_i  = 1'b0;
    instr_i  = '0;
    valid_d  = 1'b0;
    cur_test = "reset";
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    repeat (3) idle_cycle();

    cur_test = "pass_through";
    for (int i = 0; i < 200; i++) begin
      w = $random(seed);
      send_word({w[31:2], 2'b11});
    end

    cur_test = "directed";
    for (int i = 0; i < N_LEGAL; i++) begin
      w = $random(seed);
      send_word({w[31:16], LEGAL_HW[i]});
    end

    cur_test = "illegal";
    for (int i = 0; i < N_ILLEGAL; i++) begin
      w = $random(seed);
      send_word({w[31:16], ILLEGAL_HW[i]});
    end

    cur_test = "random_stream";
    for (int i = 0; i < 2000; i++) begin
      send_word($random(seed));
    end

    cur_test = "gapped_stream";
    for (int i = 0; i < 600; i++) begin
      w = $random(seed);
      if (w[2:0] < 3'd3) begin
        idle_cycle();
      end else begin
        send_word($random(seed));
      end
    end
    idle_cycle();

    // drain what is still in flight
    wait_cnt = 0;
    while (exp_q.size() != 0 && wait_cnt < 100) begin
      @(posedge clk_i);
      wait_cnt++;
    end
    repeat (2) idle_cycle();
    if (exp_q.size() != 0) begin
      $display("timed out waiting for %0d outstanding results", exp_q.size());
      $display("*** TEST FAILED ***");
      $fatal(1, "drain timeout");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

// ==== src.f ====
rtl/decomp_pkg.sv
rtl/decomp_quad0.sv
rtl/decomp_quad1.sv
rtl/decomp_quad2.sv
rtl/decomp_stage.sv
rtl/decomp_top.sv
bench/decomp_asserts.sv
bench/decomp_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile with verilator and run, pass is decided by the pass message in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module decomp_tb -o sim_decomp \
  && ./obj_dir/sim_decomp | tee /dev/stderr | grep -qF '*** TEST PASSED ***' \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
